// File: Makefile
VERILATOR  ?= verilator
TOP        ?= riscv_em_tb
FILELIST   ?= riscv_em.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wall -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) && echo "run passed" || \
	  (echo "run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/riscv_em_properties.sv
`timescale 1ns/1ps
`include "riscv_em_config.svh"

module riscv_em_properties (
  input logic                          i_riscv_em_clk,
  input logic                          i_riscv_em_rst,
  input logic                          i_riscv_em_regw_w,
  input logic [`RISCV_EM_RADDR_W-1:0]  i_riscv_em_rdaddr_w,
  input logic                          i_riscv_em_memw_m
);

  // no write in the first two cycles after reset, the pipe still holds bubbles
  a_quiet_after_reset: assert property (@(posedge i_riscv_em_clk)
    $fell(i_riscv_em_rst) |-> !i_riscv_em_regw_w ##1 !i_riscv_em_regw_w)
    else $error("write enable high right after reset release");

  a_no_x0_write: assert property (@(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
    i_riscv_em_regw_w |-> (i_riscv_em_rdaddr_w != '0))
    else $error("register write to x0");

  // a store reaches writeback with its write enable low
  a_store_no_write: assert property (@(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
    i_riscv_em_memw_m |=> !i_riscv_em_regw_w)
    else $error("store produced a register write");

endmodule

bind riscv_em_top riscv_em_properties u_props (
  .i_riscv_em_clk      (i_riscv_em_clk),
  .i_riscv_em_rst      (i_riscv_em_rst),
  .i_riscv_em_regw_w   (o_riscv_em_regw_w),
  .i_riscv_em_rdaddr_w (o_riscv_em_rdaddr_w),
  .i_riscv_em_memw_m   (em_q.memw)
);

// File: dv/riscv_em_tb.sv
`timescale 1ns/1ps
`include "riscv_em_config.svh"

module riscv_em_tb;

  localparam int N_ISSUE = 4 + 100 + 12 + 20 * 9 + 10 * 2 + 6 + 4;
  localparam int LIMIT   = N_ISSUE + 10 + 20;

  typedef struct {
    int          due;
    logic        regw;
    logic [4:0]  rd;
    logic [63:0] wdata;
    string       name;
  } exp_t;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [31:0] inst;
  logic [63:0] pc;
  logic [63:0] rs1_val;
  logic [63:0] rs2_val;
  logic        regw_w;
  logic [4:0]  rdaddr_w;
  logic [63:0] wdata_w;

  logic [63:0] shadow [`RISCV_EM_DMEM_WORDS];
  logic [31:0] lcg_state = 32'd23694;
  exp_t        exp_q[$];
  exp_t        cur;
  int          cyc = 0;
  int          since_rst = 0;
  int          errors = 0;
  int          checks = 0;

  riscv_em_top DUT (
    .i_riscv_em_clk      (clk),
    .i_riscv_em_rst      (rst),
    .i_riscv_em_inst     (inst),
    .i_riscv_em_pc       (pc),
    .i_riscv_em_rs1_val  (rs1_val),
    .i_riscv_em_rs2_val  (rs2_val),
    .o_riscv_em_regw_w   (regw_w),
    .o_riscv_em_rdaddr_w (rdaddr_w),
    .o_riscv_em_wdata_w  (wdata_w)
  );

  always #10 clk = ~clk;

  // fold the high state half into the short-period low bits
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16);
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    hi = lcg_next();
    return {hi, lcg_next()};
  endfunction

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {imm, 5'd1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [2:0] f3);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
  endfunction

  // expected write port for one instruction in program order
  function automatic exp_t ref_model(input logic [31:0] w, input logic [63:0] p,
                                     input logic [63:0] a, input logic [63:0] b);
    exp_t        e;
    logic [2:0]  f3;
    logic [63:0] op_b;
    logic [63:0] ea;
    logic [63:0] raw;
    logic        alt;
    logic        wr;
    int          nb;
    int          idx;
    int          off;
    f3 = w[14:12];
    wr = 1'b1;
    e.wdata = '0;
    nb = 1 << f3[1:0];
    case (w[6:0])
      7'b0110011, 7'b0010011:
      begin
        op_b = (w[6:0] == 7'b0110011) ? b : sext12(w[31:20]);
        alt  = w[30] && ((w[6:0] == 7'b0110011) || (f3 == 3'd5));
        case (f3)
          3'd0: e.wdata = alt ? a - op_b : a + op_b;
          3'd1: e.wdata = a << op_b[5:0];
          3'd2: e.wdata = ($signed(a) < $signed(op_b)) ? 64'd1 : 64'd0;
          3'd3: e.wdata = (a < op_b) ? 64'd1 : 64'd0;
          3'd4: e.wdata = a ^ op_b;
          3'd5: e.wdata = alt ? 64'($signed(a) >>> op_b[5:0]) : a >> op_b[5:0];
          3'd6: e.wdata = a | op_b;
          default: e.wdata = a & op_b;
        endcase
      end
      7'b0110111: e.wdata = {{32{w[31]}}, w[31:12], 12'b0};
      7'b1101111, 7'b1100111: e.wdata = p + 64'd4;
      7'b0000011:
      begin
        ea  = a + sext12(w[31:20]);
        idx = int'(ea >> 3) % `RISCV_EM_DMEM_WORDS;
        off = int'(ea[2:0]);
        raw = shadow[idx] >> (off * 8);
        for (int k = 0; k < 8; k++)
        begin
          if (k < nb)
            e.wdata[k*8 +: 8] = raw[k*8 +: 8];
          else
            e.wdata[k*8 +: 8] = (!f3[2] && raw[nb*8-1]) ? 8'hff : 8'h00;
        end
      end
      7'b0100011:
      begin
        wr  = 1'b0;
        ea  = a + sext12({w[31:25], w[11:7]});
        idx = int'(ea >> 3) % `RISCV_EM_DMEM_WORDS;
        off = int'(ea[2:0]);
        for (int k = 0; k < nb; k++)
          shadow[idx][(off+k)*8 +: 8] = b[k*8 +: 8];
      end
      default: wr = 1'b0;   // bubble
    endcase
    e.rd   = w[11:7];
    e.regw = wr && (w[11:7] != 5'd0);
    return e;
  endfunction

  task automatic issue(input logic [31:0] w, input logic [63:0] p, input logic [63:0] a,
                       input logic [63:0] b, input string name);
    exp_t e;
    inst    = w;
    pc      = p;
    rs1_val = a;
    rs2_val = b;
    e       = ref_model(w, p, a, b);
    e.due   = cyc + 2;
    e.name  = name;
    exp_q.push_back(e);
    @(negedge clk);
  endtask

  // load or store at a byte address with the base register making up the offset
  task automatic mem_op(input logic is_st, input logic [2:0] f3, input logic [63:0] addr,
                        input logic [4:0] rd, input string name);
    logic [11:0] imm;
    imm = 12'(lcg_next());
    if (is_st)
      issue(enc_s(imm, f3), rand64(), addr - sext12(imm), rand64(), name);
    else
      issue(enc_i(imm, f3, rd, 7'b0000011), rand64(), addr - sext12(imm), rand64(), name);
  endtask

  always @(posedge clk)
  begin
    if (rst)
    begin
      checks++;
      if (regw_w || rdaddr_w != '0 || wdata_w != '0)
      begin
        errors++;
        $display("write port not zero during reset at cycle %0d", cyc);
      end
    end
    else
    begin
      if (since_rst < 2)
      begin
        checks++;
        if (regw_w || rdaddr_w != '0 || wdata_w != '0)
        begin
          errors++;
          $display("write port not zero right after reset at cycle %0d", cyc);
        end
        since_rst++;
      end
      if (exp_q.size() > 0 && exp_q[0].due == cyc)
      begin
        cur = exp_q.pop_front();
        checks++;
        if (regw_w !== cur.regw)
        begin
          errors++;
          $display("ERR %s regw expected %0b actual %0b", cur.name, cur.regw, regw_w);
        end
        if (cur.regw && rdaddr_w !== cur.rd)
        begin
          errors++;
          $display("ERR %s rdaddr expected %0d actual %0d", cur.name, cur.rd, rdaddr_w);
        end
        if (cur.regw && wdata_w !== cur.wdata)
        begin
          errors++;
          $display("ERR %s wdata expected %h actual %h", cur.name, cur.wdata, wdata_w);
        end
      end
    end
    cyc++;
    if (cyc > LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial
  begin
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [63:0] addr;
    logic [63:0] la;
    int          nb;
    inst    = '0;
    pc      = '0;
    rs1_val = '0;
    rs2_val = '0;
    for (int w = 0; w < `RISCV_EM_DMEM_WORDS; w++)
      shadow[w] = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    repeat (4) issue(32'h0, 64'h0, 64'h0, 64'h0, "idle");

    for (int i = 0; i < 100; i++)
    begin
      f3 = 3'(lcg_next());
      if (lcg_next() % 2 == 0)
      begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && lcg_next() % 2 == 1) ? 7'b0100000 : 7'b0;
        issue(enc_r(f7, f3, 5'(lcg_next())), rand64(), rand64(), rand64(), "op");
      end
      else
      begin
        imm = 12'(lcg_next());
        if (f3 == 3'd1)
          imm[11:6] = 6'b0;
        else if (f3 == 3'd5)
          imm[11:6] = (lcg_next() % 2 == 1) ? 6'b010000 : 6'b0;   // srai or srli
        issue(enc_i(imm, f3, 5'(lcg_next()), 7'b0010011), rand64(), rand64(), rand64(),
              "op_imm");
      end
    end

    for (int i = 0; i < 4; i++)
    begin
      issue({~i[0], 19'(lcg_next()), 5'd3, 7'b0110111}, rand64(), rand64(), rand64(),
            "lui");
      issue({25'(lcg_next()) | 25'h1, 7'b1101111}, {rand64() & ~64'h3}, rand64(),
            rand64(), "jal");
      issue(enc_i(12'(lcg_next()), 3'd0, 5'd7, 7'b1100111), {rand64() & ~64'h3}, rand64(),
            rand64(), "jalr");
    end

    for (int i = 0; i < 20; i++)
    begin
      f3   = 3'(lcg_next() % 4);
      nb   = 1 << f3;
      addr = (lcg_next() % `RISCV_EM_DMEM_WORDS) * 8 + ((lcg_next() % 8) & ~(nb - 1));
      mem_op(1'b1, f3, addr, 5'd0, "store");
      for (int l = 0; l < 7; l++)
      begin
        la = addr & ~64'((1 << (l % 4)) - 1);
        mem_op(1'b0, 3'(l), la, 5'd9, "load");
      end
      mem_op(1'b0, 3'd3, ((addr & ~64'h7) + 8) % (`RISCV_EM_DMEM_WORDS * 8), 5'd10,
             "load_next");
    end

    for (int i = 0; i < 10; i++)
    begin
      addr = (lcg_next() % `RISCV_EM_DMEM_WORDS) * 8;
      mem_op(1'b1, 3'd3, addr, 5'd0, "b2b_store");
      mem_op(1'b0, 3'd3, addr, 5'd11, "b2b_load");
    end

    issue(enc_r(7'b0, 3'd0, 5'd0), rand64(), rand64(), rand64(), "x0_add");
    issue(enc_i(12'(lcg_next()), 3'd4, 5'd0, 7'b0010011), rand64(), rand64(), rand64(),
          "x0_xori");
    issue({20'(lcg_next()), 5'd0, 7'b0110111}, rand64(), rand64(), rand64(), "x0_lui");
    issue({20'(lcg_next()), 5'd0, 7'b1101111}, rand64(), rand64(), rand64(), "x0_jal");
    issue(enc_i(12'(lcg_next()), 3'd0, 5'd0, 7'b1100111), rand64(), rand64(), rand64(),
          "x0_jalr");
    mem_op(1'b0, 3'd3, 64'h40, 5'd0, "x0_ld");
    repeat (4) issue(32'h0, 64'h0, 64'h0, 64'h0, "drain");

    while (exp_q.size() != 0)
      @(posedge clk);
    @(negedge clk);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: riscv_em.f
+incdir+verilog
verilog/riscv_em_pkg.sv
verilog/riscv_em_ctrl.sv
verilog/riscv_em_alu.sv
verilog/riscv_em_ppreg.sv
verilog/riscv_em_memstage.sv
verilog/riscv_em_top.sv
dv/riscv_em_properties.sv
dv/riscv_em_tb.sv

// File: verilog/riscv_em_alu.sv
`timescale 1ns/1ps
`include "riscv_em_config.svh"

module riscv_em_alu (
  input  riscv_em_pkg::riscv_em_ctrl_t i_riscv_em_ctrl,
  input  logic [`RISCV_EM_XLEN-1:0]    i_riscv_em_rs1_val,
  input  logic [`RISCV_EM_XLEN-1:0]    i_riscv_em_rs2_val,
  input  logic [`RISCV_EM_XLEN-1:0]    i_riscv_em_imm,
  input  logic [`RISCV_EM_XLEN-1:0]    i_riscv_em_pc,
  output logic [`RISCV_EM_XLEN-1:0]    o_riscv_em_result_e,
  output logic [`RISCV_EM_XLEN-1:0]    o_riscv_em_pcplus4_e
);

  import riscv_em_pkg::*;

  logic [`RISCV_EM_XLEN-1:0] op_a;
  logic [`RISCV_EM_XLEN-1:0] op_b;
  logic [5:0]                shamt;
  logic                      lt_s;
  logic                      lt_u;

  assign op_a  = i_riscv_em_rs1_val;
  assign op_b  = i_riscv_em_ctrl.alusrc ? i_riscv_em_imm : i_riscv_em_rs2_val;
  assign shamt = op_b[5:0];

  assign lt_s = $signed(op_a) < $signed(op_b);
  assign lt_u = op_a < op_b;

  // loads and stores produce the effective address here
  always_comb
  begin
    case (i_riscv_em_ctrl.aluop)
      ALU_ADD:  o_riscv_em_result_e = op_a + op_b;
      ALU_SUB:  o_riscv_em_result_e = op_a - op_b;
      ALU_AND:  o_riscv_em_result_e = op_a & op_b;
      ALU_OR:   o_riscv_em_result_e = op_a | op_b;
      ALU_XOR:  o_riscv_em_result_e = op_a ^ op_b;
      ALU_SLL:  o_riscv_em_result_e = op_a << shamt;
      ALU_SRL:  o_riscv_em_result_e = op_a >> shamt;
      ALU_SRA:  o_riscv_em_result_e = $signed(op_a) >>> shamt;
      ALU_SLT:  o_riscv_em_result_e = {{(`RISCV_EM_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: o_riscv_em_result_e = {{(`RISCV_EM_XLEN-1){1'b0}}, lt_u};
      default:  o_riscv_em_result_e = '0;
    endcase
  end

  assign o_riscv_em_pcplus4_e = i_riscv_em_pc + `RISCV_EM_XLEN'(4);   // link value

endmodule

// File: verilog/riscv_em_config.svh
`ifndef RISCV_EM_CONFIG_SVH
`define RISCV_EM_CONFIG_SVH

// integer data path width, also the width of one data memory word
`define RISCV_EM_XLEN 64

// register file address width
`define RISCV_EM_RADDR_W 5

// data memory depth in XLEN words
`define RISCV_EM_DMEM_WORDS 256

`endif

// File: verilog/riscv_em_ctrl.sv
`timescale 1ns/1ps
`include "riscv_em_config.svh"

module riscv_em_ctrl (
  input  logic [31:0]                    i_riscv_em_inst,
  output riscv_em_pkg::riscv_em_ctrl_t   o_riscv_em_ctrl,
  output logic [`RISCV_EM_XLEN-1:0]      o_riscv_em_imm,
  output riscv_em_pkg::riscv_em_opcode_e o_riscv_em_opcode
);

  import riscv_em_pkg::*;

  riscv_em_opcode_e              opcode;
  logic [2:0]                    funct3;
  logic [6:0]                    funct7;
  logic [`RISCV_EM_RADDR_W-1:0]  rd;
  logic                          alt_op;
  riscv_em_aluop_e               arith_op;
  logic                          wr_en;
  logic [`RISCV_EM_XLEN-1:0]     imm_i;
  logic [`RISCV_EM_XLEN-1:0]     imm_s;
  logic [`RISCV_EM_XLEN-1:0]     imm_u;
  logic [`RISCV_EM_XLEN-1:0]     imm_j;

  assign opcode = riscv_em_opcode_e'(i_riscv_em_inst[6:0]);
  assign funct3 = i_riscv_em_inst[14:12];
  assign funct7 = i_riscv_em_inst[31:25];
  assign rd     = i_riscv_em_inst[11:7];

  // for OP-IMM funct7[5] only counts on the right shifts, addi has no subtract form
  assign alt_op = funct7[5] & ((opcode == OPC_OP) | (funct3 == 3'b101));

  assign imm_i = {{(`RISCV_EM_XLEN-12){i_riscv_em_inst[31]}}, i_riscv_em_inst[31:20]};
  assign imm_s = {{(`RISCV_EM_XLEN-12){i_riscv_em_inst[31]}}, i_riscv_em_inst[31:25],
                  i_riscv_em_inst[11:7]};
  assign imm_u = {{(`RISCV_EM_XLEN-32){i_riscv_em_inst[31]}}, i_riscv_em_inst[31:12], 12'b0};
  assign imm_j = {{(`RISCV_EM_XLEN-21){i_riscv_em_inst[31]}}, i_riscv_em_inst[31],
                  i_riscv_em_inst[19:12], i_riscv_em_inst[20], i_riscv_em_inst[30:21], 1'b0};

  always_comb
  begin
    case (funct3)
      3'b000: arith_op = alt_op ? ALU_SUB : ALU_ADD;
      3'b001: arith_op = ALU_SLL;
      3'b010: arith_op = ALU_SLT;
      3'b011: arith_op = ALU_SLTU;
      3'b100: arith_op = ALU_XOR;
      3'b101: arith_op = alt_op ? ALU_SRA : ALU_SRL;
      3'b110: arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb
  begin
    o_riscv_em_ctrl = '0;
    o_riscv_em_imm  = '0;
    wr_en           = 1'b0;
    o_riscv_em_ctrl.aluop     = ALU_ADD;
    o_riscv_em_ctrl.resultsrc = RES_ALU;
    case (opcode)
      OPC_OP:
      begin
        wr_en                 = 1'b1;
        o_riscv_em_ctrl.aluop = arith_op;
      end
      OPC_OP_IMM:
      begin
        wr_en                  = 1'b1;
        o_riscv_em_ctrl.aluop  = arith_op;
        o_riscv_em_ctrl.alusrc = 1'b1;
        o_riscv_em_imm         = imm_i;   // shifts take only the low six bits
      end
      OPC_LUI:
      begin
        wr_en                     = 1'b1;
        o_riscv_em_ctrl.resultsrc = RES_IMM;
        o_riscv_em_imm            = imm_u;
      end
      OPC_JAL:
      begin
        wr_en                     = 1'b1;
        o_riscv_em_ctrl.resultsrc = RES_PCPLUS4;
        o_riscv_em_imm            = imm_j;
      end
      OPC_JALR:
      begin
        wr_en                     = 1'b1;
        o_riscv_em_ctrl.resultsrc = RES_PCPLUS4;
        o_riscv_em_ctrl.alusrc    = 1'b1;
        o_riscv_em_imm            = imm_i;
      end
      OPC_LOAD:
      begin
        wr_en                     = 1'b1;
        o_riscv_em_ctrl.resultsrc = RES_MEM;
        o_riscv_em_ctrl.alusrc    = 1'b1;
        o_riscv_em_ctrl.memext    = funct3;
        o_riscv_em_imm            = imm_i;
      end
      OPC_STORE:
      begin
        o_riscv_em_ctrl.memw     = 1'b1;
        o_riscv_em_ctrl.alusrc   = 1'b1;
        o_riscv_em_ctrl.storesrc = funct3[1:0];
        o_riscv_em_imm           = imm_s;
      end
      default: ;   // unknown opcode runs as a bubble
    endcase
    o_riscv_em_ctrl.regw   = wr_en & (rd != '0);
    o_riscv_em_ctrl.rdaddr = rd;
  end

  assign o_riscv_em_opcode = opcode;

endmodule

// File: verilog/riscv_em_memstage.sv
`timescale 1ns/1ps
`include "riscv_em_config.svh"

module riscv_em_memstage (
  input  logic                       i_riscv_em_clk,
  input  logic                       i_riscv_em_rst,
  input  riscv_em_pkg::riscv_em_em_t i_riscv_em_em,
  output riscv_em_pkg::riscv_em_mw_t o_riscv_em_mw
);

  import riscv_em_pkg::*;

  localparam int IDX_W = $clog2(`RISCV_EM_DMEM_WORDS);
  localparam int XLEN  = `RISCV_EM_XLEN;

  logic [XLEN-1:0]  dmem [`RISCV_EM_DMEM_WORDS];
  logic [IDX_W-1:0] word_idx;
  logic [2:0]       byte_off;
  logic [7:0]       width_mask;
  logic [7:0]       st_mask;
  logic [XLEN-1:0]  st_data;
  logic [XLEN-1:0]  rd_shift;
  logic [XLEN-1:0]  load_data;

  assign word_idx = i_riscv_em_em.result[IDX_W+2:3];
  assign byte_off = i_riscv_em_em.result[2:0];

  always_comb
  begin
    case (i_riscv_em_em.storesrc)
      2'b00:   width_mask = 8'h01;
      2'b01:   width_mask = 8'h03;
      2'b10:   width_mask = 8'h0f;
      default: width_mask = 8'hff;
    endcase
  end

  assign st_mask = width_mask << byte_off;
  assign st_data = i_riscv_em_em.storedata << {byte_off, 3'b000};   // align to lane

  always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
  begin
    if (i_riscv_em_rst)
    begin
      for (int w = 0; w < `RISCV_EM_DMEM_WORDS; w++)
      begin
        dmem[w] <= '0;
      end
    end
    else if (i_riscv_em_em.memw)
    begin
      for (int b = 0; b < 8; b++)
      begin
        if (st_mask[b])
        begin
          dmem[word_idx][8*b +: 8] <= st_data[8*b +: 8];
        end
      end
    end
  end

  assign rd_shift = dmem[word_idx] >> {byte_off, 3'b000};

  always_comb
  begin
    case (i_riscv_em_em.memext)
      3'b000:  load_data = {{(XLEN-8){rd_shift[7]}}, rd_shift[7:0]};     // lb
      3'b001:  load_data = {{(XLEN-16){rd_shift[15]}}, rd_shift[15:0]};  // lh
      3'b010:  load_data = {{(XLEN-32){rd_shift[31]}}, rd_shift[31:0]};  // lw
      3'b100:  load_data = {{(XLEN-8){1'b0}}, rd_shift[7:0]};
      3'b101:  load_data = {{(XLEN-16){1'b0}}, rd_shift[15:0]};
      3'b110:  load_data = {{(XLEN-32){1'b0}}, rd_shift[31:0]};
      default: load_data = rd_shift;                                     // ld
    endcase
  end

  always_comb
  begin
    o_riscv_em_mw.regw   = i_riscv_em_em.regw;
    o_riscv_em_mw.rdaddr = i_riscv_em_em.rdaddr;
    case (i_riscv_em_em.resultsrc)
      RES_MEM:     o_riscv_em_mw.wdata = load_data;
      RES_PCPLUS4: o_riscv_em_mw.wdata = i_riscv_em_em.pcplus4;
      RES_IMM:     o_riscv_em_mw.wdata = i_riscv_em_em.imm;
      default:     o_riscv_em_mw.wdata = i_riscv_em_em.result;
    endcase
  end

endmodule

// File: verilog/riscv_em_pkg.sv
`include "riscv_em_config.svh"

package riscv_em_pkg;

  // major opcodes, bits [6:0] of the instruction word
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } riscv_em_opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } riscv_em_aluop_e;

  typedef enum logic [1:0] {
    RES_ALU     = 2'd0,
    RES_MEM     = 2'd1,
    RES_PCPLUS4 = 2'd2,
    RES_IMM     = 2'd3
  } riscv_em_resultsrc_e;

  typedef struct packed {
    logic                          regw;
    logic                          memw;
    riscv_em_resultsrc_e           resultsrc;
    logic [1:0]                    storesrc;   // 0 byte .. 3 double
    logic [2:0]                    memext;     // load funct3
    riscv_em_aluop_e               aluop;
    logic                          alusrc;     // 1 selects the immediate
    logic [`RISCV_EM_RADDR_W-1:0]  rdaddr;
  } riscv_em_ctrl_t;

  // execute to memory payload
  typedef struct packed {
    logic                          memw;
    logic                          regw;
    riscv_em_resultsrc_e           resultsrc;
    logic [1:0]                    storesrc;
    logic [2:0]                    memext;
    logic [`RISCV_EM_XLEN-1:0]     pcplus4;
    logic [`RISCV_EM_XLEN-1:0]     result;
    logic [`RISCV_EM_XLEN-1:0]     storedata;
    logic [`RISCV_EM_RADDR_W-1:0]  rdaddr;
    logic [`RISCV_EM_XLEN-1:0]     imm;
    riscv_em_opcode_e              opcode;
    logic [31:0]                   inst;
  } riscv_em_em_t;

  // memory to writeback payload
  typedef struct packed {
    logic                          regw;
    logic [`RISCV_EM_RADDR_W-1:0]  rdaddr;
    logic [`RISCV_EM_XLEN-1:0]     wdata;
  } riscv_em_mw_t;

endpackage

// File: verilog/riscv_em_ppreg.sv
`timescale 1ns/1ps

module riscv_em_ppreg #(
  parameter type T_PAYLOAD = logic
) (
  input  logic     i_riscv_em_clk,
  input  logic     i_riscv_em_rst,
  input  T_PAYLOAD i_riscv_em_d,
  output T_PAYLOAD o_riscv_em_q
);

  // zero payload is a bubble, both write enables low
  always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
  begin
    if (i_riscv_em_rst)
    begin
      o_riscv_em_q <= '0;
    end
    else
    begin
      o_riscv_em_q <= i_riscv_em_d;
    end
  end

endmodule

// File: verilog/riscv_em_top.sv
`timescale 1ns/1ps
`include "riscv_em_config.svh"

module riscv_em_top (
  input  logic                          i_riscv_em_clk,
  input  logic                          i_riscv_em_rst,
  input  logic [31:0]                   i_riscv_em_inst,
  input  logic [`RISCV_EM_XLEN-1:0]     i_riscv_em_pc,
  input  logic [`RISCV_EM_XLEN-1:0]     i_riscv_em_rs1_val,
  input  logic [`RISCV_EM_XLEN-1:0]     i_riscv_em_rs2_val,
  output logic                          o_riscv_em_regw_w,
  output logic [`RISCV_EM_RADDR_W-1:0]  o_riscv_em_rdaddr_w,
  output logic [`RISCV_EM_XLEN-1:0]     o_riscv_em_wdata_w
);

  import riscv_em_pkg::*;

  riscv_em_ctrl_t            ctrl;
  logic [`RISCV_EM_XLEN-1:0] imm;
  riscv_em_opcode_e          opcode;
  logic [`RISCV_EM_XLEN-1:0] result_e;
  logic [`RISCV_EM_XLEN-1:0] pcplus4_e;
  riscv_em_em_t              em_d;
  riscv_em_em_t              em_q;
  riscv_em_mw_t              mw_d;
  riscv_em_mw_t              mw_q;

  riscv_em_ctrl u_ctrl (
    .i_riscv_em_inst   (i_riscv_em_inst),
    .o_riscv_em_ctrl   (ctrl),
    .o_riscv_em_imm    (imm),
    .o_riscv_em_opcode (opcode)
  );

  riscv_em_alu u_alu (
    .i_riscv_em_ctrl      (ctrl),
    .i_riscv_em_rs1_val   (i_riscv_em_rs1_val),
    .i_riscv_em_rs2_val   (i_riscv_em_rs2_val),
    .i_riscv_em_imm       (imm),
    .i_riscv_em_pc        (i_riscv_em_pc),
    .o_riscv_em_result_e  (result_e),
    .o_riscv_em_pcplus4_e (pcplus4_e)
  );

  always_comb
  begin
    em_d.memw      = ctrl.memw;
    em_d.regw      = ctrl.regw;
    em_d.resultsrc = ctrl.resultsrc;
    em_d.storesrc  = ctrl.storesrc;
    em_d.memext    = ctrl.memext;
    em_d.pcplus4   = pcplus4_e;
    em_d.result    = result_e;
    em_d.storedata = i_riscv_em_rs2_val;   // store data is always rs2
    em_d.rdaddr    = ctrl.rdaddr;
    em_d.imm       = imm;
    em_d.opcode    = opcode;
    em_d.inst      = i_riscv_em_inst;
  end

  riscv_em_ppreg #(.T_PAYLOAD(riscv_em_em_t)) u_em_ppreg (
    .i_riscv_em_clk (i_riscv_em_clk),
    .i_riscv_em_rst (i_riscv_em_rst),
    .i_riscv_em_d   (em_d),
    .o_riscv_em_q   (em_q)
  );

  riscv_em_memstage u_memstage (
    .i_riscv_em_clk (i_riscv_em_clk),
    .i_riscv_em_rst (i_riscv_em_rst),
    .i_riscv_em_em  (em_q),
    .o_riscv_em_mw  (mw_d)
  );

  riscv_em_ppreg #(.T_PAYLOAD(riscv_em_mw_t)) u_mw_ppreg (
    .i_riscv_em_clk (i_riscv_em_clk),
    .i_riscv_em_rst (i_riscv_em_rst),
    .i_riscv_em_d   (mw_d),
    .o_riscv_em_q   (mw_q)
  );

  assign o_riscv_em_regw_w   = mw_q.regw;
  assign o_riscv_em_rdaddr_w = mw_q.rdaddr;
  assign o_riscv_em_wdata_w  = mw_q.wdata;

endmodule
